//--- Makefile
TOP := snd_board_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build snd_board with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -f snd_board.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- hw/snd_audio_pkg.sv
// audio sample types and fixed mix gains; sample rate is clk / sample_div, no gain registers
package snd_audio_pkg;

    typedef logic signed [15:0] sample_t;      // mixed or tone sample
    typedef logic signed [7:0]  pcm_sample_t;  // signed pcm byte
    typedef logic [16:0]        pcm_addr_t;    // bit 16 selects the bank
    typedef logic [7:0]         pcm_len_t;     // samples left to play
    typedef logic [15:0]        tone_period_t; // half-period in ticks

    localparam int sample_div   = 64;  // clocks per sample tick
    localparam int sample_div_w = $clog2(sample_div);

    typedef logic [sample_div_w-1:0] tick_cnt_t;

    localparam tick_cnt_t tick_last = tick_cnt_t'(sample_div - 1);

    // output gains as left shifts
    localparam int tone_shift = 7;  // amplitude * 128
    localparam int pcm_shift  = 6;  // pcm * 64

endpackage

//--- hw/snd_board.sv
// sound board driven by an external host in place of the sound CPU; mono, one pcm channel
`timescale 1ns/1ps

module snd_board (
    input  logic                       clk,
    input  logic                       rst,
    // host port
    input  logic                       host_req,
    input  snd_bus_pkg::bus_req_t      host_bus,
    output logic                       host_ack,
    output snd_bus_pkg::bus_data_t     host_rdata,
    // program ROM
    output logic                       rom_cs,
    output snd_bus_pkg::rom_addr_t     rom_addr,
    input  snd_bus_pkg::bus_data_t     rom_data,
    input  logic                       rom_ok,
    // main board
    input  logic                       snd_irq,
    input  snd_bus_pkg::bus_data_t     snd_latch,
    output logic                       irq,
    // sample ROM
    output logic                       pcm_cs,
    output snd_audio_pkg::pcm_addr_t   pcm_addr,
    input  snd_bus_pkg::bus_data_t     pcm_data,
    input  logic                       pcm_ok,
    // audio
    output snd_audio_pkg::sample_t     snd,
    output logic                       sample,
    output logic                       peak
);

    snd_bus_pkg::bus_req_t       reg_req;
    snd_bus_pkg::ram_addr_t      ram_addr;
    snd_bus_pkg::bus_data_t      ram_rdata;
    snd_audio_pkg::sample_t      tone_out;
    snd_audio_pkg::pcm_sample_t  pcm_out;
    logic                        ram_we;
    logic                        pcm_we;
    logic                        tone_we;
    logic                        pcm_bank;
    logic                        pcm_busy;
    logic                        sample_tick;

    snd_bus_ctrl u_ctrl (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .host_req    ( host_req    ),
        .host_bus    ( host_bus    ),
        .host_ack    ( host_ack    ),
        .host_rdata  ( host_rdata  ),
        .rom_cs      ( rom_cs      ),
        .rom_addr    ( rom_addr    ),
        .rom_data    ( rom_data    ),
        .rom_ok      ( rom_ok      ),
        .snd_irq     ( snd_irq     ),
        .snd_latch   ( snd_latch   ),
        .irq         ( irq         ),
        .reg_req     ( reg_req     ),
        .ram_we      ( ram_we      ),
        .ram_addr    ( ram_addr    ),
        .ram_rdata   ( ram_rdata   ),
        .pcm_we      ( pcm_we      ),
        .pcm_busy    ( pcm_busy    ),
        .tone_we     ( tone_we     ),
        .pcm_bank    ( pcm_bank    ),
        .sample_tick ( sample_tick )
    );

    snd_ram u_ram (
        .clk   ( clk           ),
        .we    ( ram_we        ),
        .addr  ( ram_addr      ),
        .wdata ( reg_req.wdata ),
        .rdata ( ram_rdata     )
    );

    snd_pcm_channel u_pcm (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .we          ( pcm_we      ),
        .reg_req     ( reg_req     ),
        .bank        ( pcm_bank    ),
        .sample_tick ( sample_tick ),
        .pcm_cs      ( pcm_cs      ),
        .pcm_addr    ( pcm_addr    ),
        .pcm_data    ( pcm_data    ),
        .pcm_ok      ( pcm_ok      ),
        .pcm_out     ( pcm_out     ),
        .busy        ( pcm_busy    )
    );

    snd_tone_gen u_tone (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .we          ( tone_we     ),
        .reg_req     ( reg_req     ),
        .sample_tick ( sample_tick ),
        .tone_out    ( tone_out    )
    );

    snd_mixer u_mixer (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .sample_tick ( sample_tick ),
        .tone_in     ( tone_out    ),
        .pcm_in      ( pcm_out     ),
        .snd         ( snd         ),
        .sample      ( sample      ),
        .peak        ( peak        )
    );

endmodule

//--- hw/snd_bus_ctrl.sv
// one host access at a time; rom_ok must come eventually or the handshake hangs
`timescale 1ns/1ps

module snd_bus_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    host_req,
    input  snd_bus_pkg::bus_req_t   host_bus,
    output logic                    host_ack,
    output snd_bus_pkg::bus_data_t  host_rdata,
    output logic                    rom_cs,
    output snd_bus_pkg::rom_addr_t  rom_addr,
    input  snd_bus_pkg::bus_data_t  rom_data,
    input  logic                    rom_ok,
    input  logic                    snd_irq,
    input  snd_bus_pkg::bus_data_t  snd_latch,
    output logic                    irq,
    output snd_bus_pkg::bus_req_t   reg_req,
    output logic                    ram_we,
    output snd_bus_pkg::ram_addr_t  ram_addr,
    input  snd_bus_pkg::bus_data_t  ram_rdata,
    output logic                    pcm_we,
    input  logic                    pcm_busy,
    output logic                    tone_we,
    output logic                    pcm_bank,
    output logic                    sample_tick
);

    typedef enum logic [2:0] {
        st_idle,
        st_decode,
        st_wait_rom,
        st_wait_ram,
        st_respond,
        st_release
    } state_e;

    state_e                  state;
    snd_bus_pkg::region_e    region;
    snd_bus_pkg::bus_data_t  read_mux;
    snd_audio_pkg::tick_cnt_t tick_cnt;
    logic                    write_cycle;
    logic                    latch_done;
    logic                    irq_last;

    // decode from the held request
    always_comb begin
        if (!reg_req.addr[15]) begin
            region = snd_bus_pkg::region_rom;
        end else begin
            case (reg_req.addr[14:12])
                3'd0:    region = snd_bus_pkg::region_ram;
                3'd2:    region = snd_bus_pkg::region_latch;
                3'd3:    region = snd_bus_pkg::region_pcm;
                3'd4:    region = snd_bus_pkg::region_tone;
                3'd7:    region = snd_bus_pkg::region_bank;
                default: region = snd_bus_pkg::region_none;
            endcase
        end
    end

    always_comb begin
        case (region)
            snd_bus_pkg::region_ram:   read_mux = ram_rdata;
            snd_bus_pkg::region_latch: read_mux = snd_latch;
            snd_bus_pkg::region_pcm:   read_mux = {7'd0, pcm_busy};
            snd_bus_pkg::region_bank:  read_mux = {7'd0, pcm_bank};
            default:                   read_mux = snd_bus_pkg::unmapped_data; // tone is write only
        endcase
    end

    assign write_cycle = (state == st_decode) && reg_req.we; // strobes last this one clock
    assign ram_we      = write_cycle && (region == snd_bus_pkg::region_ram);
    assign pcm_we      = write_cycle && (region == snd_bus_pkg::region_pcm);
    assign tone_we     = write_cycle && (region == snd_bus_pkg::region_tone);
    assign latch_done  = (state == st_wait_ram) && (region == snd_bus_pkg::region_latch);

    assign rom_cs   = (state == st_wait_rom);
    assign rom_addr = reg_req.addr[14:0];
    assign ram_addr = reg_req.addr[10:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_idle;
            host_ack   <= 1'b0;
            host_rdata <= '0;
            reg_req    <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (host_req) begin
                        reg_req <= host_bus;
                        state   <= st_decode;
                    end
                end
                st_decode: begin
                    if (reg_req.we) begin
                        host_ack <= 1'b1;
                        state    <= st_respond;
                    end else if (region == snd_bus_pkg::region_rom) begin
                        state <= st_wait_rom;
                    end else begin
                        state <= st_wait_ram; // ram data needs one more clock
                    end
                end
                st_wait_rom: begin
                    if (rom_ok) begin
                        host_rdata <= rom_data;
                        host_ack   <= 1'b1;
                        state      <= st_respond;
                    end
                end
                st_wait_ram: begin
                    host_rdata <= read_mux;
                    host_ack   <= 1'b1;
                    state      <= st_respond;
                end
                st_respond: begin
                    if (!host_req) begin
                        host_ack <= 1'b0;
                        state    <= st_release;
                    end
                end
                default: state <= st_idle; // release
            endcase
        end
    end

    // bank bit and latch interrupt
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pcm_bank <= 1'b0;
            irq      <= 1'b0;
            irq_last <= 1'b0;
        end else begin
            irq_last <= snd_irq;
            if (write_cycle && region == snd_bus_pkg::region_bank) begin
                pcm_bank <= reg_req.wdata[0];
            end
            if (snd_irq && !irq_last) begin
                irq <= 1'b1; // a new edge wins over the clear
            end else if (latch_done) begin
                irq <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt <= '0;
        end else if (sample_tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign sample_tick = (tick_cnt == snd_audio_pkg::tick_last);

endmodule

//--- hw/snd_bus_pkg.sv
// host bus types and memory map; regions are decoded on address bits 15:12 only
package snd_bus_pkg;

    typedef logic [15:0] bus_addr_t;    // host address
    typedef logic [7:0]  bus_data_t;    // one data byte
    typedef logic [14:0] rom_addr_t;    // program ROM, 32 KB
    typedef logic [10:0] ram_addr_t;    // work RAM, 2 KB

    // decoded target of a host access
    typedef enum logic [2:0] {
        region_rom,     // 0000-7fff
        region_ram,     // 8xxx
        region_latch,   // axxx
        region_pcm,     // bxxx
        region_tone,    // cxxx
        region_bank,    // fxxx
        region_none     // reads back as unmapped_data
    } region_e;

    // request as seen on the host port
    typedef struct packed {
        bus_addr_t addr;
        logic      we;
        bus_data_t wdata;
    } bus_req_t;

    localparam bus_data_t unmapped_data = 8'hff;

endpackage

//--- hw/snd_mixer.sv
// mono mixer with fixed gains; the sum clips to 16 bits and peak marks a clipped sample
`timescale 1ns/1ps

module snd_mixer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sample_tick,
    input  snd_audio_pkg::sample_t     tone_in,
    input  snd_audio_pkg::pcm_sample_t pcm_in,
    output snd_audio_pkg::sample_t     snd,
    output logic                       sample,
    output logic                       peak
);

    logic signed [16:0]     tone_ext;
    logic signed [16:0]     pcm_ext;
    logic signed [16:0]     sum;   // one guard bit
    logic                   clip;
    snd_audio_pkg::sample_t sat;

    assign tone_ext = {tone_in[15], tone_in};
    assign pcm_ext  = {{9{pcm_in[7]}}, pcm_in} <<< snd_audio_pkg::pcm_shift;
    assign sum      = tone_ext + pcm_ext;
    assign clip     = (sum[16] != sum[15]);

    always_comb begin
        if (!clip) begin
            sat = sum[15:0];
        end else if (sum[16]) begin
            sat = 16'sh8000;  // most negative
        end else begin
            sat = 16'sh7fff;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd    <= '0;
            peak   <= 1'b0;
            sample <= 1'b0;
        end else begin
            sample <= sample_tick; // new value visible with this pulse
            if (sample_tick) begin
                snd  <= sat;
                peak <= clip;
            end
        end
    end

endmodule

//--- hw/snd_pcm_channel.sv
// one-shot 8-bit player; the sample ROM must answer within sample_div - 4 clocks, no looping
`timescale 1ns/1ps

module snd_pcm_channel (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       we,
    input  snd_bus_pkg::bus_req_t      reg_req,
    input  logic                       bank,
    input  logic                       sample_tick,
    output logic                       pcm_cs,
    output snd_audio_pkg::pcm_addr_t   pcm_addr,
    input  snd_bus_pkg::bus_data_t     pcm_data,
    input  logic                       pcm_ok,
    output snd_audio_pkg::pcm_sample_t pcm_out,
    output logic                       busy
);

    snd_bus_pkg::bus_data_t  start_lo;
    snd_bus_pkg::bus_data_t  start_hi;
    snd_audio_pkg::pcm_len_t length;
    snd_audio_pkg::pcm_len_t remain;   // bytes still to fetch
    logic                    trigger;

    assign trigger = we && (reg_req.addr[1:0] == 2'd3);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_lo <= '0;
            start_hi <= '0;
            length   <= '0;
        end else if (we) begin
            if (reg_req.addr[1:0] == 2'd0) begin
                start_lo <= reg_req.wdata;
            end else if (reg_req.addr[1:0] == 2'd1) begin
                start_hi <= reg_req.wdata;
            end else if (reg_req.addr[1:0] == 2'd2) begin
                length <= reg_req.wdata;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pcm_cs   <= 1'b0;
            pcm_addr <= '0;
            pcm_out  <= '0;
            remain   <= '0;
            busy     <= 1'b0;
        end else if (trigger) begin
            pcm_addr <= {bank, start_hi, start_lo};
            remain   <= length;
            busy     <= (length != '0); // zero length plays nothing
            pcm_cs   <= 1'b0;
            pcm_out  <= '0;
        end else if (pcm_cs) begin
            if (pcm_ok) begin
                pcm_cs         <= 1'b0;
                pcm_out        <= {~pcm_data[7], pcm_data[6:0]}; // offset binary to signed
                pcm_addr[15:0] <= pcm_addr[15:0] + 1'b1;         // stays inside the bank
                remain         <= remain - 1'b1;
            end
        end else if (sample_tick && busy) begin
            if (remain != '0) begin
                pcm_cs <= 1'b1;
            end else begin
                // last byte was mixed on this tick
                busy    <= 1'b0;
                pcm_out <= '0;
            end
        end
    end

endmodule

//--- hw/snd_ram.sv
// single port work RAM; read data follows the address by one clock, contents not reset
`timescale 1ns/1ps

module snd_ram (
    input  logic                   clk,
    input  logic                   we,
    input  snd_bus_pkg::ram_addr_t addr,
    input  snd_bus_pkg::bus_data_t wdata,
    output snd_bus_pkg::bus_data_t rdata
);

    // 2048 bytes
    snd_bus_pkg::bus_data_t mem [0:(1 << $bits(snd_bus_pkg::ram_addr_t))-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // old data on a write cycle
    end

endmodule

//--- hw/snd_tone_gen.sv
// square wave only, no envelope; a zero half-period mutes the output
`timescale 1ns/1ps

module snd_tone_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   we,
    input  snd_bus_pkg::bus_req_t  reg_req,
    input  logic                   sample_tick,
    output snd_audio_pkg::sample_t tone_out
);

    snd_audio_pkg::tone_period_t half_period;
    snd_audio_pkg::tone_period_t phase_cnt;
    snd_bus_pkg::bus_data_t      amp;
    snd_audio_pkg::sample_t      level;
    logic                        negative;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            half_period <= '0;
            amp         <= '0;
            phase_cnt   <= '0;
            negative    <= 1'b0;
        end else if (we) begin
            if (reg_req.addr[1:0] == 2'd0) begin
                half_period[7:0] <= reg_req.wdata;
            end else if (reg_req.addr[1:0] == 2'd1) begin
                half_period[15:8] <= reg_req.wdata;
            end else if (reg_req.addr[1:0] == 2'd2) begin
                amp <= reg_req.wdata;
            end
            phase_cnt <= '0;  // any write restarts high
            negative  <= 1'b0;
        end else if (sample_tick && half_period != '0) begin
            if (phase_cnt == half_period - 1'b1) begin
                phase_cnt <= '0;
                negative  <= ~negative;
            end else begin
                phase_cnt <= phase_cnt + 1'b1;
            end
        end
    end

    // 255 * 128 still fits the positive range
    assign level = snd_audio_pkg::sample_t'({8'd0, amp}) <<< snd_audio_pkg::tone_shift;

    always_comb begin
        if (half_period == '0) begin
            tone_out = '0;
        end else if (negative) begin
            tone_out = -level;
        end else begin
            tone_out = level;
        end
    end

endmodule

//--- snd_board.f
hw/snd_bus_pkg.sv
hw/snd_audio_pkg.sv
hw/snd_bus_ctrl.sv
hw/snd_ram.sv
hw/snd_pcm_channel.sv
hw/snd_tone_gen.sv
hw/snd_mixer.sv
hw/snd_board.sv
test/snd_board_tb.sv

//--- test/snd_board_tb.sv
// directed tests at a 4 ns clock; ROM models answer with LFSR delays well inside one sample period
`timescale 1ns/1ps

module snd_board_tb;

    localparam int timeout_cycles = 20000; // about 30 sample periods of 64 clocks, ten times over

    logic                       clk;
    logic                       rst;
    logic                       host_req;
    snd_bus_pkg::bus_req_t      host_bus;
    logic                       host_ack;
    snd_bus_pkg::bus_data_t     host_rdata;
    logic                       rom_cs;
    snd_bus_pkg::rom_addr_t     rom_addr;
    snd_bus_pkg::bus_data_t     rom_data;
    logic                       rom_ok;
    logic                       snd_irq;
    snd_bus_pkg::bus_data_t     snd_latch;
    logic                       irq;
    logic                       pcm_cs;
    snd_audio_pkg::pcm_addr_t   pcm_addr;
    snd_bus_pkg::bus_data_t     pcm_data;
    logic                       pcm_ok;
    snd_audio_pkg::sample_t     snd;
    logic                       sample;
    logic                       peak;

    logic [31:0]                lfsr_state = 32'h1c542539;
    snd_audio_pkg::pcm_addr_t   pcm_reqs [$];  // every address the sample ROM was asked for
    int                         checks;
    int                         errors;
    int                         cycles;

    snd_board uut (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .host_req   ( host_req   ),
        .host_bus   ( host_bus   ),
        .host_ack   ( host_ack   ),
        .host_rdata ( host_rdata ),
        .rom_cs     ( rom_cs     ),
        .rom_addr   ( rom_addr   ),
        .rom_data   ( rom_data   ),
        .rom_ok     ( rom_ok     ),
        .snd_irq    ( snd_irq    ),
        .snd_latch  ( snd_latch  ),
        .irq        ( irq        ),
        .pcm_cs     ( pcm_cs     ),
        .pcm_addr   ( pcm_addr   ),
        .pcm_data   ( pcm_data   ),
        .pcm_ok     ( pcm_ok     ),
        .snd        ( snd        ),
        .sample     ( sample     ),
        .peak       ( peak       )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // offset binary byte from the sample ROM, scaled by 64
    function automatic snd_audio_pkg::sample_t pcm_expect(input snd_bus_pkg::bus_data_t raw);
        logic signed [7:0] s;
        s = raw ^ 8'h80;
        return snd_audio_pkg::sample_t'(int'(s) * 64);
    endfunction

    function automatic snd_audio_pkg::sample_t clamp(input int v);
        if (v > 32767) begin
            return 16'sh7fff;
        end else if (v < -32768) begin
            return 16'sh8000;
        end
        return snd_audio_pkg::sample_t'(v);
    endfunction

    task automatic check_data(input string what, input snd_bus_pkg::bus_data_t got,
                              input snd_bus_pkg::bus_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_sample(input string what, input snd_audio_pkg::sample_t got,
                                input snd_audio_pkg::sample_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input string what, input snd_audio_pkg::pcm_addr_t got,
                              input snd_audio_pkg::pcm_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s got 0x%05h expected 0x%05h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // program ROM, low address byte xor high address byte
    initial begin
        rom_ok   = 1'b0;
        rom_data = '0;
        forever begin
            @(negedge clk);
            if (rom_cs) begin
                repeat (take_bits(3)) @(negedge clk);
                rom_data = rom_addr[7:0] ^ {1'b0, rom_addr[14:8]};
                rom_ok   = 1'b1;
                @(negedge clk);
                rom_ok = 1'b0;
            end
        end
    end

    // sample ROM, low address byte xor 0x5a
    initial begin
        pcm_ok   = 1'b0;
        pcm_data = '0;
        forever begin
            @(negedge clk);
            if (pcm_cs) begin
                pcm_reqs.push_back(pcm_addr);
                repeat (take_bits(4)) @(negedge clk);
                pcm_data = pcm_addr[7:0] ^ 8'h5a;
                pcm_ok   = 1'b1;
                @(negedge clk);
                pcm_ok = 1'b0;
            end
        end
    end

    task automatic host_write(input snd_bus_pkg::bus_addr_t addr,
                              input snd_bus_pkg::bus_data_t data);
        @(negedge clk);
        host_bus.addr  = addr;
        host_bus.we    = 1'b1;
        host_bus.wdata = data;
        host_req       = 1'b1;
        @(negedge clk);
        while (!host_ack) @(negedge clk);
        host_req = 1'b0;
        while (host_ack) @(negedge clk);
    endtask

    task automatic host_read(input snd_bus_pkg::bus_addr_t addr,
                             output snd_bus_pkg::bus_data_t data);
        @(negedge clk);
        host_bus.addr  = addr;
        host_bus.we    = 1'b0;
        host_bus.wdata = '0;
        host_req       = 1'b1;
        @(negedge clk);
        while (!host_ack) @(negedge clk);
        data     = host_rdata;
        host_req = 1'b0;
        while (host_ack) @(negedge clk);
    endtask

    task automatic wait_sample();
        @(negedge clk);
        while (!sample) @(negedge clk);
    endtask

    task automatic ram_readback();
        snd_bus_pkg::bus_addr_t addr_list [8];
        snd_bus_pkg::bus_data_t data_list [8];
        snd_bus_pkg::bus_data_t exp;
        snd_bus_pkg::bus_data_t got;
        int                     i;
        int                     j;
        for (i = 0; i < 8; i++) begin
            addr_list[i] = 16'h8000 | snd_bus_pkg::bus_addr_t'(take_bits(11));
            data_list[i] = snd_bus_pkg::bus_data_t'(take_bits(8));
            host_write(addr_list[i], data_list[i]);
        end
        for (i = 0; i < 8; i++) begin
            exp = data_list[i];
            for (j = i + 1; j < 8; j++) begin
                if (addr_list[j] == addr_list[i]) begin
                    exp = data_list[j]; // a later write to the same byte wins
                end
            end
            host_read(addr_list[i], got);
            check_data($sformatf("ram read 0x%04h", addr_list[i]), got, exp);
        end
        host_read(16'hd000, got);
        check_data("unmapped read 0xd000", got, 8'hff);
    endtask

    task automatic rom_fetch();
        snd_bus_pkg::bus_addr_t addr;
        snd_bus_pkg::bus_data_t got;
        int                     i;
        for (i = 0; i < 6; i++) begin
            addr = snd_bus_pkg::bus_addr_t'(take_bits(15));
            host_read(addr, got);
            check_data($sformatf("rom read 0x%04h", addr), got, addr[7:0] ^ addr[15:8]);
        end
    endtask

    task automatic latch_irq();
        snd_bus_pkg::bus_data_t latch_val;
        snd_bus_pkg::bus_data_t got;
        latch_val = snd_bus_pkg::bus_data_t'(take_bits(8));
        @(negedge clk);
        snd_latch = latch_val;
        check_flag("irq before the edge", irq, 1'b0);
        snd_irq = 1'b1;
        repeat (2) @(negedge clk);
        check_flag("irq after the edge", irq, 1'b1);
        host_read(16'ha000, got);
        check_data("latch read", got, latch_val);
        check_flag("irq after latch read", irq, 1'b0);
        snd_irq = 1'b0;
    endtask

    task automatic tone_pattern();
        int i;
        int level;
        wait_sample(); // writes land well before the next tick
        host_write(16'hc002, 8'd40);
        host_write(16'hc001, 8'd0);
        host_write(16'hc000, 8'd3);
        for (i = 0; i < 12; i++) begin
            wait_sample();
            level = (((i / 3) % 2) == 0) ? 40 * 128 : -(40 * 128);
            check_sample($sformatf("tone pulse %0d", i), snd, snd_audio_pkg::sample_t'(level));
        end
    endtask

    task automatic pcm_playback();
        snd_bus_pkg::bus_data_t status;
        snd_bus_pkg::bus_data_t raw;
        int                     i;
        host_write(16'hc002, 8'd0);  // tone silent
        host_write(16'hf000, 8'h01); // bank 1
        host_write(16'hb000, 8'h30);
        host_write(16'hb001, 8'h12);
        host_write(16'hb002, 8'd6);
        pcm_reqs.delete();
        wait_sample();
        host_write(16'hb003, 8'h00);
        wait_sample();
        check_sample("first pulse after trigger", snd, 16'sd0);
        host_read(16'hb000, status);
        check_data("pcm status while playing", status, 8'h01);
        for (i = 0; i < 6; i++) begin
            wait_sample();
            raw = (8'h30 + 8'(i)) ^ 8'h5a;
            check_sample($sformatf("pcm sample %0d", i), snd, pcm_expect(raw));
        end
        wait_sample();
        check_sample("after the last pcm sample", snd, 16'sd0);
        host_read(16'hb000, status);
        check_data("pcm status after playback", status, 8'h00);
        checks++;
        if (pcm_reqs.size() != 6) begin
            errors++;
            $display("FAILED %0t: sample ROM saw %0d requests, expected 6", $time, pcm_reqs.size());
        end
        for (i = 0; i < 6 && i < pcm_reqs.size(); i++) begin
            check_addr($sformatf("sample ROM request %0d", i), pcm_reqs[i], 17'h11230 + 17'(i));
        end
    endtask

    task automatic mix_saturation();
        snd_bus_pkg::bus_data_t raw;
        int                     sum;
        host_write(16'hc000, 8'h00);
        host_write(16'hc001, 8'h01); // 256 ticks per half-period, stays positive
        host_write(16'hc002, 8'hff);
        host_write(16'hb000, 8'ha5);
        host_write(16'hb001, 8'h00);
        host_write(16'hb002, 8'd1);
        pcm_reqs.delete();
        raw = 8'ha5 ^ 8'h5a;
        sum = 255 * 128 + int'(pcm_expect(raw));
        wait_sample();
        host_write(16'hb003, 8'h00);
        wait_sample();
        check_sample("full tone alone", snd, clamp(255 * 128));
        check_flag("peak with full tone alone", peak, 1'b0);
        wait_sample();
        check_sample("tone plus pcm", snd, clamp(sum));
        check_flag("peak on tone plus pcm", peak, (sum > 32767) || (sum < -32768));
        wait_sample();
        check_flag("peak after pcm ends", peak, 1'b0);
        checks++;
        if (pcm_reqs.size() != 1) begin
            errors++;
            $display("FAILED %0t: sample ROM saw %0d requests, expected 1", $time, pcm_reqs.size());
        end else begin
            check_addr("saturation sample request", pcm_reqs[0], 17'h100a5);
        end
        wait_sample();
        host_write(16'hc002, 8'd10);
        wait_sample();
        check_sample("tone at amplitude 10", snd, clamp(10 * 128));
        check_flag("peak at amplitude 10", peak, 1'b0);
    endtask

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles with tests unfinished, %0d errors so far",
                 cycles, errors);
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        host_req  = 1'b0;
        host_bus  = '0;
        snd_irq   = 1'b0;
        snd_latch = '0;
        checks    = 0;
        errors    = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        ram_readback();
        rom_fetch();
        latch_irq();
        tone_pattern();
        pcm_playback();
        mix_saturation();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
